/* sim.f */
bp_pkg.sv
inst_predecode.sv
return_stack.sv
next_pc_select.sv
fetch_predict_top.sv
tb_fetch_predict.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch prediction testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_fetch_predict

verilator --binary --timing --assert \
    -f sim.f \
    --top-module "$TOP" \
    --Mdir obj_dir \
    -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

/* tb_fetch_predict.sv */
/*
 * fetch prediction testbench
 * applies a table of instruction steps to the fetch front end and
 * checks pc and next_pc against a behavioral stack and priority model
 */
`timescale 1ns/10ps

module tb_fetch_predict;
    import bp_pkg::*;

    // same values as the top level defaults
    localparam int          RAS_DEPTH     = 8;
    localparam logic [31:0] RESET_PC      = 32'h0000_1000;
    localparam int          RESET_CYCLES  = 16;
    localparam int          MARGIN_CYCLES = 40;

    typedef enum {
        k_plain, k_idle, k_call, k_ret, k_jump, k_jalr, k_brf, k_brb,
        k_stall_call, k_stall_ret, k_redirect, k_redirect_stall
    } step_kind_e;

    // imm of zero means pick one at random
    typedef struct {
        step_kind_e  kind;
        logic [31:0] imm;
        int          tag;
    } step_t;

    logic        clock;
    logic        reset;
    logic [31:0] inst;
    logic        inst_valid;
    logic        stall;
    redirect_t   redirect;
    logic [31:0] pc;
    logic [31:0] next_pc;

    step_t       steps[$];
    bit          table_built;
    logic [31:0] rng_state;
    // reference model state
    logic [31:0] model_pc;
    logic [31:0] model_fallback;
    logic [31:0] model_stack[$];
    logic [31:0] exp_next;
    int          error_count;
    int          test_checks;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    string       test_names[5];

    fetch_predict_top i_dut (
        .clock      (clock),
        .reset      (reset),
        .inst       (inst),
        .inst_valid (inst_valid),
        .stall      (stall),
        .redirect   (redirect),
        .pc         (pc),
        .next_pc    (next_pc)
    );

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // xorshift32
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // word multiple offsets, branch range kept inside 4 KiB
    function automatic logic [31:0] pick_imm(input step_kind_e kind);
        logic [31:0] r;
        logic [31:0] val;
        r = next_random();
        if (kind == k_brf || kind == k_brb) begin
            val = {21'd0, r[10:2], 2'b00} + 32'd4;
            return (kind == k_brb) ? 32'd0 - val : val;
        end
        val = {18'd0, r[13:2], 2'b00} + 32'd4;
        return r[20] ? 32'd0 - val : val;
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [4:0] rs1, input logic [4:0] rs2,
                                               input logic [31:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic add_step(input step_kind_e kind, input logic [31:0] imm, input int tag);
        step_t st;
        st.kind = kind;
        st.imm  = imm;
        st.tag  = tag;
        steps.push_back(st);
    endtask

    task automatic build_table();
        // sequential fetch, then inst_valid low
        add_step(k_plain, 0, 0);
        add_step(k_plain, 0, 0);
        add_step(k_plain, 0, 0);
        add_step(k_idle, 0, 0);
        add_step(k_idle, 0, 0);
        add_step(k_plain, 0, 0);
        // direct jumps and static branch direction
        add_step(k_jump, 32'h0000_0100, 1);
        add_step(k_brb, 0, 1);
        add_step(k_brf, 0, 1);
        add_step(k_jalr, 0, 1);
        add_step(k_jump, 32'hffff_ff00, 1);
        add_step(k_brf, 0, 1);
        add_step(k_brb, 0, 1);
        add_step(k_jump, 0, 1);
        // nothing pushed yet, so returns fall through
        add_step(k_ret, 0, 2);
        add_step(k_redirect, 32'h0000_2000, 2);
        add_step(k_ret, 0, 2);
        add_step(k_call, 0, 2);
        add_step(k_redirect, 32'h0000_3000, 2);
        add_step(k_ret, 0, 2);
        add_step(k_ret, 0, 2);
        add_step(k_redirect_stall, 32'h0000_4000, 2);
        add_step(k_ret, 0, 2);
        add_step(k_plain, 0, 2);
        // nested calls, then overflow past the depth
        add_step(k_call, 0, 3);
        add_step(k_call, 0, 3);
        add_step(k_call, 0, 3);
        add_step(k_ret, 0, 3);
        add_step(k_ret, 0, 3);
        add_step(k_call, 0, 3);
        add_step(k_ret, 0, 3);
        add_step(k_ret, 0, 3);
        for (int i = 0; i < RAS_DEPTH + 2; i++) begin
            add_step(k_call, 0, 3);
        end
        for (int i = 0; i < RAS_DEPTH + 3; i++) begin
            add_step(k_ret, 0, 3);
        end
        // stall holds pc and stack
        add_step(k_call, 0, 4);
        add_step(k_stall_call, 0, 4);
        add_step(k_stall_ret, 0, 4);
        add_step(k_stall_ret, 0, 4);
        add_step(k_ret, 0, 4);
        add_step(k_stall_call, 0, 4);
        add_step(k_plain, 0, 4);
        add_step(k_ret, 0, 4);
    endtask

    // drive one step, 1 ns after the edge
    task automatic drive_step(input step_t st, output logic [31:0] imm);
        logic [31:0] r;
        logic [4:0]  link;
        logic [31:0] imm_v;
        r     = next_random();
        link  = r[0] ? 5'd5 : 5'd1;
        imm_v = (st.imm != 32'd0) ? st.imm : pick_imm(st.kind);
        inst_valid = 1'b1;
        stall      = 1'b0;
        redirect   = '0;
        case (st.kind)
            k_idle: begin
                // a call pattern that must be ignored
                inst       = enc_jal(link, imm_v);
                inst_valid = 1'b0;
            end
            k_call:      inst = enc_jal(link, imm_v);
            k_ret:       inst = enc_jalr(5'd0, link, r[31:20]);
            k_jump:      inst = enc_jal(r[1] ? 5'd10 : 5'd0, imm_v);
            // neither a call nor a return
            k_jalr:      inst = enc_jalr(r[1] ? 5'd10 : 5'd0, r[1] ? link : 5'd6, r[31:20]);
            k_brf, k_brb: inst = enc_branch(r[19:15], r[24:20], imm_v);
            k_stall_call: begin
                inst  = enc_jal(link, imm_v);
                stall = 1'b1;
            end
            k_stall_ret: begin
                inst  = enc_jalr(5'd0, link, r[31:20]);
                stall = 1'b1;
            end
            k_redirect: begin
                // return pattern that the redirect must override
                inst            = enc_jalr(5'd0, link, r[31:20]);
                redirect.valid  = 1'b1;
                redirect.target = imm_v;
            end
            k_redirect_stall: begin
                inst            = enc_jal(link, pick_imm(k_call));
                stall           = 1'b1;
                redirect.valid  = 1'b1;
                redirect.target = imm_v;
            end
            default:     inst = {r[31:7], 7'b0010011};
        endcase
        imm = imm_v;
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model and checks
    //////////////////////////////////////////////////////////////////////

    // expected next_pc now, then the state after the edge
    task automatic run_model(input step_kind_e kind, input logic [31:0] imm);
        logic [31:0] seq;
        seq      = model_pc + 32'd4;
        exp_next = seq;
        case (kind)
            k_redirect, k_redirect_stall: exp_next = imm;
            k_call, k_stall_call, k_jump, k_brb: exp_next = model_pc + imm;
            k_ret, k_stall_ret: begin
                if (model_stack.size() != 0) begin
                    exp_next = model_stack[$];
                end else if (model_fallback != 32'd0) begin
                    exp_next = model_fallback;
                end
            end
            default: exp_next = seq;
        endcase
        if (kind == k_redirect || kind == k_redirect_stall) begin
            model_stack.delete();
            model_pc = imm;
        end else if (kind == k_call) begin
            model_stack.push_back(seq);
            // oldest entry lost on overflow
            if (model_stack.size() > RAS_DEPTH) begin
                void'(model_stack.pop_front());
            end
            model_fallback = seq;
            model_pc       = exp_next;
        end else if (kind == k_ret) begin
            if (model_stack.size() != 0) begin
                void'(model_stack.pop_back());
            end
            model_pc = exp_next;
        end else if (kind != k_stall_call && kind != k_stall_ret) begin
            model_pc = exp_next;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        test_checks++;
        if (got !== exp) begin
            $display("ERR %0d ns: %s is %h, expected %h", $time, name, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic report_test(input int tag);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: ok, %0d checks", test_names[tag], test_checks);
        end else begin
            tests_failed++;
            $display("test %s: failed, %0d of %0d checks wrong",
                     test_names[tag], test_errors, test_checks);
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // clock, watchdog, main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // table length plus reset plus margin, in 10 ns cycles
    initial begin
        wait (table_built);
        #((steps.size() + RESET_CYCLES + MARGIN_CYCLES) * 10);
        $display("timeout: the test sequence did not complete in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] imm;
        reset        = 1'b1;
        inst         = 32'd0;
        inst_valid   = 1'b0;
        stall        = 1'b0;
        redirect     = '0;
        rng_state    = 32'd26;
        error_count  = 0;
        test_checks  = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_names   = '{"sequential", "direct_flow", "redirect", "call_return", "stall"};
        build_table();
        table_built = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset          = 1'b0;
        model_pc       = RESET_PC;
        model_fallback = 32'd0;
        model_stack.delete();
        // pc straight out of reset
        check_value("pc", pc, model_pc);
        for (int i = 0; i < steps.size(); i++) begin
            if (i > 0 && steps[i].tag != steps[i-1].tag) begin
                report_test(steps[i-1].tag);
            end
            drive_step(steps[i], imm);
            run_model(steps[i].kind, imm);
            #4;
            check_value("next_pc", next_pc, exp_next);
            @(posedge clock);
            #1;
            check_value("pc", pc, model_pc);
        end
        report_test(steps[steps.size()-1].tag);
        inst_valid = 1'b0;
        stall      = 1'b0;
        redirect   = '0;
        $display("tests passed %0d, tests failed %0d, mismatches %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* fetch_predict_top.sv */
/*
 * fetch prediction top
 * predecode, return address stack and next-pc select for an rv32
 * fetch stage
 */
`timescale 1ns/10ps

module fetch_predict_top #(
    parameter int                      RAS_DEPTH = 8,
    parameter logic [bp_pkg::XLEN-1:0] RESET_PC  = 32'h0000_1000
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [bp_pkg::XLEN-1:0] inst,
    input  logic                    inst_valid,
    input  logic                    stall,
    input  bp_pkg::redirect_t       redirect,
    output logic [bp_pkg::XLEN-1:0] pc,
    output logic [bp_pkg::XLEN-1:0] next_pc
);
    import bp_pkg::*;

    // decode result, shared by stack and selector
    predecode_t pd;
    // stack prediction for returns
    ras_pred_t  ras;

    //////////////////////////////////////////////////////////////////////
    // decode, stack, select
    //////////////////////////////////////////////////////////////////////

    inst_predecode i_predecode (
        .pc         (pc),
        .inst       (inst),
        .inst_valid (inst_valid),
        .pd         (pd)
    );

    // a redirect squashes the stack
    return_stack #(
        .RAS_DEPTH (RAS_DEPTH)
    ) i_stack (
        .clock  (clock),
        .reset  (reset),
        .squash (redirect.valid),
        .stall  (stall),
        .pc     (pc),
        .pd     (pd),
        .ras    (ras)
    );

    next_pc_select #(
        .RESET_PC (RESET_PC)
    ) i_select (
        .clock    (clock),
        .reset    (reset),
        .stall    (stall),
        .pd       (pd),
        .ras      (ras),
        .redirect (redirect),
        .pc       (pc),
        .next_pc  (next_pc)
    );

endmodule

/* next_pc_select.sv */
/*
 * next-pc select
 * priority mux of redirect, stack prediction, direct target and
 * static branch direction, plus the fetch pc register
 */
`timescale 1ns/10ps

module next_pc_select #(
    parameter logic [bp_pkg::XLEN-1:0] RESET_PC = 32'h0000_1000
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    stall,
    input  bp_pkg::predecode_t      pd,
    input  bp_pkg::ras_pred_t       ras,
    input  bp_pkg::redirect_t       redirect,
    output logic [bp_pkg::XLEN-1:0] pc,
    output logic [bp_pkg::XLEN-1:0] next_pc
);
    import bp_pkg::*;

    // which source feeds next_pc
    typedef enum logic [1:0] {
        sel_seq,
        sel_redirect,
        sel_ras,
        sel_target
    } sel_src_e;

    sel_src_e        sel_src;
    logic [XLEN-1:0] seq_pc;

    assign seq_pc = pc + 32'd4;

    //////////////////////////////////////////////////////////////////////
    // source priority
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        sel_src = sel_seq;
        if (redirect.valid) begin
            // resolve stage always wins
            sel_src = sel_redirect;
        end else if ((pd.cls == class_return) && ras.valid) begin
            sel_src = sel_ras;
        end else if ((pd.cls == class_call) || (pd.cls == class_jump)) begin
            sel_src = sel_target;
        end else if ((pd.cls == class_branch) && pd.backward) begin
            // backward taken, forward not taken
            sel_src = sel_target;
        end
    end

    always_comb begin
        case (sel_src)
            sel_redirect: next_pc = redirect.target;
            sel_ras:      next_pc = ras.addr;
            sel_target:   next_pc = pd.target;
            default:      next_pc = seq_pc;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // fetch pc register
    //////////////////////////////////////////////////////////////////////

    // redirect loads even through a stall
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (redirect.valid || !stall) begin
            pc <= next_pc;
        end
    end

    // word aligned fetch, no compressed support
    a_pc_aligned: assert property (
        @(posedge clock) disable iff (reset)
        pc[1:0] == 2'b00
    ) else $error("fetch pc misaligned");

endmodule

/* return_stack.sv */
/*
 * return address stack
 * circular stack of return addresses with saturating count, cleared
 * by squash, with a fallback register holding the last pushed address
 */
`timescale 1ns/10ps

module return_stack #(
    parameter int RAS_DEPTH = 8
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    squash,
    input  logic                    stall,
    input  logic [bp_pkg::XLEN-1:0] pc,
    input  bp_pkg::predecode_t      pd,
    output bp_pkg::ras_pred_t       ras
);
    import bp_pkg::*;

    localparam int PTR_W = $clog2(RAS_DEPTH);
    localparam int CNT_W = $clog2(RAS_DEPTH + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(RAS_DEPTH);

    logic [XLEN-1:0]  entries [RAS_DEPTH];
    logic [PTR_W-1:0] top_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    // last pushed address, survives squash
    logic [XLEN-1:0]  fallback;
    logic [XLEN-1:0]  ret_addr;
    logic             push;
    logic             pop;
    logic             not_empty;

    //////////////////////////////////////////////////////////////////////
    // push and pop strobes
    //////////////////////////////////////////////////////////////////////

    assign ret_addr  = pc + 32'd4;
    assign not_empty = (count != '0);

    // squash and stall block both
    assign push = (pd.cls == class_call) && !stall && !squash;
    assign pop  = (pd.cls == class_return) && !stall && !squash && not_empty;

    //////////////////////////////////////////////////////////////////////
    // stack state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            for (int i = 0; i < RAS_DEPTH; i++) begin
                entries[i] <= '0;
            end
            count   <= '0;
            top_ptr <= '0;
            wr_ptr  <= '0;
            // only a real reset drops the fallback
            if (reset) begin
                fallback <= '0;
            end
        end else if (push) begin
            entries[wr_ptr] <= ret_addr;
            top_ptr         <= wr_ptr;
            // wraps onto the oldest entry when full
            wr_ptr          <= wr_ptr + 1'b1;
            fallback        <= ret_addr;
            if (count != CNT_MAX) begin
                count <= count + 1'b1;
            end
        end else if (pop) begin
            wr_ptr  <= top_ptr;
            top_ptr <= top_ptr - 1'b1;
            count   <= count - 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // prediction
    //////////////////////////////////////////////////////////////////////

    // empty stack falls back to the last pushed address
    assign ras.addr  = not_empty ? entries[top_ptr] : fallback;
    assign ras.valid = (pd.cls == class_return) && (not_empty || (fallback != '0));

    // count saturates, never runs past the entry array
    a_count_bound: assert property (
        @(posedge clock) disable iff (reset)
        count <= CNT_MAX
    ) else $error("return stack count above depth");

    // class is one-hot in effect, so never both in a cycle
    a_push_pop_excl: assert property (
        @(posedge clock) disable iff (reset)
        !(push && pop)
    ) else $error("return stack push and pop together");

endmodule

/* inst_predecode.sv */
/*
 * instruction predecode
 * classifies the fetched instruction as call, return, jump or branch
 * and computes the pc-relative target of jal and conditional branches
 */
`timescale 1ns/10ps

module inst_predecode (
    input  logic [bp_pkg::XLEN-1:0] pc,
    input  logic [bp_pkg::XLEN-1:0] inst,
    input  logic                    inst_valid,
    output bp_pkg::predecode_t      pd
);
    import bp_pkg::*;

    opcode_e         op;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic            rd_link;
    logic            rs1_link;
    logic [XLEN-1:0] j_imm;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] seq_pc;

    //////////////////////////////////////////////////////////////////////
    // field extraction
    //////////////////////////////////////////////////////////////////////

    assign op  = opcode_e'(inst[6:0]);
    assign rd  = inst[11:7];
    assign rs1 = inst[19:15];

    // x1 (ra) and x5 (t0) are the link registers
    assign rd_link  = (rd == 5'd1) || (rd == 5'd5);
    assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

    // j-type immediate, bit 0 implied zero
    assign j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // b-type immediate, bit 0 implied zero
    assign b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    assign seq_pc = pc + 32'd4;

    //////////////////////////////////////////////////////////////////////
    // classification
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // default is sequential, no control flow
        pd.cls      = class_none;
        pd.target   = seq_pc;
        pd.backward = 1'b0;
        if (inst_valid) begin
            case (op)
                op_jal: begin
                    // jal to a link register is a call
                    pd.cls    = rd_link ? class_call : class_jump;
                    pd.target = pc + j_imm;
                end
                op_jalr: begin
                    // register target unknown here, target stays pc+4
                    if (rd_link) begin
                        pd.cls = class_call;
                    end else if ((rd == 5'd0) && rs1_link) begin
                        pd.cls = class_return;
                    end
                end
                op_branch: begin
                    pd.cls      = class_branch;
                    pd.target   = pc + b_imm;
                    // sign bit decides static direction
                    pd.backward = b_imm[XLEN-1];
                end
                default: begin
                    pd.cls = class_none;
                end
            endcase
        end
    end

endmodule

/* bp_pkg.sv */
/*
 * branch prediction package
 * shared address width, instruction class and opcode encodings, and
 * the structs passed between predecode, return stack and next-pc select
 */
package bp_pkg;

    // rv32 only, decode rules assume 32-bit instructions
    localparam int XLEN = 32;

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    // predecode result class
    typedef enum logic [2:0] {
        class_none,
        class_call,
        class_return,
        class_jump,
        class_branch
    } inst_class_e;

    // major opcodes of interest, inst[6:0]
    typedef enum logic [6:0] {
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111
    } opcode_e;

    //////////////////////////////////////////////////////////////////////
    // structs
    //////////////////////////////////////////////////////////////////////

    // predecode output, to stack and selector
    typedef struct packed {
        inst_class_e     cls;
        logic [XLEN-1:0] target;
        // branch immediate negative
        logic            backward;
    } predecode_t;

    // resolve stage correction
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

    // stack prediction for a return
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] addr;
    } ras_pred_t;

endpackage
